// File: logic/icache.sv
/* 4-way set-associative instruction cache, 256 sets of one word
   sweeps tags at reset, hits in one cycle, refills a missed word through refill_req/fetch */
`default_nettype none

module icache (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              read_en,
  input  icache_pkg::addr_t read_addr,
  output icache_pkg::word_t rdata,
  output logic              cache_miss,
  output logic              refill_req,   // one-cycle pulse on entering REFILL
  output icache_pkg::addr_t refill_addr,
  input  logic              fetch,        // refill word valid this cycle
  input  icache_pkg::word_t write_data
);
  import icache_pkg::*;

  localparam int SETS = 2 ** INDEX_BITS;

  typedef enum logic [1:0] {SWEEP, IDLE, READ, REFILL} state_t;

  state_t state;
  index_t sweep_cnt;
  addr_t  addr_q;     // sampled read address
  logic   stale;      // tag RAM output is not for addr_q yet

  tag_entry_t way_tags  [WAYS];
  tag_entry_t next_tags [WAYS];
  tag_entry_t tag_wdata [WAYS];
  word_t      way_data  [WAYS];

  logic [WAYS-1:0]     hit_vec;
  logic [WAYS-1:0]     data_we;
  logic [TAG_BITS-1:0] req_tag;
  index_t              req_idx;
  index_t              tag_addr;
  index_t              data_addr;
  way_t                hit_way;
  way_t                sel_way;
  logic hit, rd_hit, wb_need, accept, fill, retag;
  logic tag_en, tag_we, data_en;

  assign req_tag = addr_q[ADDR_BITS-1 -: TAG_BITS];
  assign req_idx = addr_q[2 +: INDEX_BITS];

  // first matching way
  always_comb begin
    hit_way = '0;
    for (int i = WAYS - 1; i >= 0; i--) begin
      if (hit_vec[i]) hit_way = way_t'(i);
    end
  end

  assign hit     = |hit_vec;
  assign rd_hit  = (state == READ) && !stale && hit;
  assign wb_need = rd_hit && (way_tags[hit_way].age != '0);  // MRU hit leaves ages alone
  assign accept  = read_en && ((state == IDLE) || rd_hit);    // new read issued this edge
  assign fill    = (state == REFILL) && fetch;
  assign retag   = (state == READ) && stale;                   // reread tags after a write

  // tag port is shared, a write-back wins over a new tag read
  assign tag_we = (state == SWEEP) || wb_need || fill;
  assign tag_en = tag_we || accept || retag;

  always_comb begin
    if (state == SWEEP)
      tag_addr = sweep_cnt;
    else if (tag_we || retag)
      tag_addr = req_idx;
    else
      tag_addr = read_addr[2 +: INDEX_BITS];
  end

  assign data_en   = accept || fill;
  assign data_addr = fill ? req_idx : read_addr[2 +: INDEX_BITS];

  always_comb begin
    case (state)
      SWEEP:   cache_miss = 1'b1;
      READ:    cache_miss = stale || !hit;
      REFILL:  cache_miss = !fetch;  // drops in the fill cycle
      default: cache_miss = 1'b0;
    endcase
  end

  assign rdata       = way_data[hit_way];
  assign refill_addr = addr_q;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state      <= SWEEP;
      sweep_cnt  <= '0;
      stale      <= 1'b0;
      refill_req <= 1'b0;
    end else begin
      refill_req <= 1'b0;
      stale      <= wb_need && read_en;  // overlapped read lost its tag slot
      case (state)
        SWEEP: begin
          sweep_cnt <= sweep_cnt + 1'b1;
          if (&sweep_cnt) state <= IDLE;  // last set written
        end
        IDLE: if (read_en) state <= READ;
        READ: begin
          if (!stale && !hit) begin
            state      <= REFILL;
            refill_req <= 1'b1;
          end else if (!stale && !read_en) begin
            state <= IDLE;
          end
        end
        REFILL: if (fetch) state <= IDLE;  // processor reissues the read
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) addr_q <= read_addr;
  end

  lru_ctrl lru0 (
    .tags      (way_tags),
    .hit_way   (hit_way),
    .use_hit   (state == READ),
    .new_tag   (req_tag),
    .sel_way   (sel_way),
    .next_tags (next_tags)
  );

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    // sweep entry is invalid with age = way number
    assign tag_wdata[w] = (state == SWEEP)
                        ? tag_entry_t'{valid: 1'b0, age: age_t'(w), tag: {TAG_BITS{1'b0}}}
                        : next_tags[w];
    assign hit_vec[w]   = way_tags[w].valid && (way_tags[w].tag == req_tag);
    assign data_we[w]   = fill && (sel_way == way_t'(w));  // victim way only

    sync_ram #(.DEPTH(SETS), .payload_t(word_t)) data_ram (
      .CLK   (CLK),
      .en    (data_en),
      .we    (data_we[w]),
      .addr  (data_addr),
      .wdata (write_data),
      .rdata (way_data[w])
    );

    sync_ram #(.DEPTH(SETS), .payload_t(tag_entry_t)) tag_ram (
      .CLK   (CLK),
      .en    (tag_en),
      .we    (tag_we),      // whole set rewritten together
      .addr  (tag_addr),
      .wdata (tag_wdata[w]),
      .rdata (way_tags[w])
    );
  end

endmodule

`default_nettype wire

// File: logic/icache_pkg.sv
/* icache package
   address split, word and tag-entry types shared by the cache and its memory path */
`default_nettype none

package icache_pkg;

  parameter int ADDR_BITS  = 20;  // byte address, 1 MB space
  parameter int INDEX_BITS = 8;   // addr[9:2]
  parameter int TAG_BITS   = 10;  // addr[19:10]
  parameter int WAYS       = 4;
  parameter int WORD_BITS  = 32;

  typedef logic [ADDR_BITS-1:0]  addr_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [1:0]            way_t;   // 0 = A .. 3 = D
  typedef logic [1:0]            age_t;   // 0 = most recently used
  typedef logic [WORD_BITS-1:0]  word_t;

  // one tag RAM word, 13 bits
  typedef struct packed {
    logic                valid;
    age_t                age;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

endpackage

`default_nettype wire

// File: logic/icache_top.sv
/* instruction cache subsystem
   cache, refill controller and main memory wired together */
`default_nettype none

module icache_top #(
  parameter int MEM_LATENCY = 3,
  parameter int MEM_WORDS   = 1024
) (
  input  logic                         CLK,
  input  logic                         rst_n,
  input  logic                         read_en,
  input  icache_pkg::addr_t            read_addr,
  output icache_pkg::word_t            rdata,
  output logic                         cache_miss,
  input  logic                         load_en,    // boot load into main memory
  input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
  input  icache_pkg::word_t            load_data
);
  import icache_pkg::*;

  localparam int MEM_AW = $clog2(MEM_WORDS);

  logic              refill_req;
  addr_t             refill_addr;
  logic              fetch;
  word_t             write_data;
  logic              mem_rd_en;
  logic [MEM_AW-1:0] mem_rd_addr;
  word_t             mem_rd_data;

  icache icache0 (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .rdata       (rdata),
    .cache_miss  (cache_miss),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .fetch       (fetch),
    .write_data  (write_data)
  );

  refill_ctrl #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) refill0 (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data),
    .fetch       (fetch),
    .write_data  (write_data)
  );

  main_mem #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) mem0 (
    .CLK       (CLK),
    .rd_en     (mem_rd_en),
    .rd_addr   (mem_rd_addr),
    .rd_data   (mem_rd_data),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

endmodule

`default_nettype wire

// File: logic/lru_ctrl.sv
/* LRU way selection for one set
   picks hit way or victim and computes the aged tag set to write back */
`default_nettype none

module lru_ctrl (
  input  icache_pkg::tag_entry_t          tags [icache_pkg::WAYS],
  input  icache_pkg::way_t                hit_way,
  input  logic                            use_hit,  // 1 = hit update, 0 = refill
  input  logic [icache_pkg::TAG_BITS-1:0] new_tag,
  output icache_pkg::way_t                sel_way,
  output icache_pkg::tag_entry_t          next_tags [icache_pkg::WAYS]
);
  import icache_pkg::*;

  way_t free_way;
  way_t old_way;
  way_t victim;
  logic found_free;
  age_t max_age;
  age_t sel_age;

  always_comb begin
    // lowest invalid way
    free_way   = '0;
    found_free = 1'b0;
    for (int i = WAYS - 1; i >= 0; i--) begin
      if (!tags[i].valid) begin
        free_way   = way_t'(i);
        found_free = 1'b1;
      end
    end
    // oldest way, strict compare so the lower index wins a tie
    old_way = '0;
    max_age = tags[0].age;
    for (int i = 1; i < WAYS; i++) begin
      if (tags[i].age > max_age) begin
        old_way = way_t'(i);
        max_age = tags[i].age;
      end
    end
    victim = found_free ? free_way : old_way;
  end

  assign sel_way = use_hit ? hit_way : victim;
  assign sel_age = tags[sel_way].age;  // age before this access

  always_comb begin
    for (int i = 0; i < WAYS; i++) begin
      next_tags[i] = tags[i];
      if (way_t'(i) == sel_way) begin
        next_tags[i].age = '0;  // now most recent
        if (!use_hit) begin
          next_tags[i].valid = 1'b1;
          next_tags[i].tag   = new_tag;
        end
      end else if (tags[i].age < sel_age) begin
        next_tags[i].age = tags[i].age + 2'd1;  // younger ways shift up, stays a permutation
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/main_mem.sv
/* main memory in block RAM, word addressed
   load port for boot loading, read data after a fixed pipeline latency */
`default_nettype none

module main_mem #(
  parameter int MEM_LATENCY = 3,  // 1 to 8
  parameter int MEM_WORDS   = 1024
) (
  input  logic                         CLK,
  input  logic                         rd_en,
  input  logic [$clog2(MEM_WORDS)-1:0] rd_addr,
  output icache_pkg::word_t            rd_data,
  input  logic                         load_en,
  input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
  input  icache_pkg::word_t            load_data
);
  import icache_pkg::*;

  word_t mem  [MEM_WORDS];
  word_t pipe [MEM_LATENCY];  // stage 0 is the RAM output register

  always_ff @(posedge CLK) begin
    if (load_en) mem[load_addr] <= load_data;
    if (rd_en) pipe[0] <= mem[rd_addr];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      pipe[i] <= pipe[i-1];  // reads can overlap
    end
  end

  assign rd_data = pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: logic/refill_ctrl.sv
/* refill controller
   issues one main-memory read per refill request and returns the word as a fetch pulse */
`default_nettype none

module refill_ctrl #(
  parameter int MEM_LATENCY = 3,
  parameter int MEM_WORDS   = 1024
) (
  input  logic                         CLK,
  input  logic                         rst_n,
  input  logic                         refill_req,
  input  icache_pkg::addr_t            refill_addr,
  output logic                         mem_rd_en,
  output logic [$clog2(MEM_WORDS)-1:0] mem_rd_addr,
  input  icache_pkg::word_t            mem_rd_data,
  output logic                         fetch,
  output icache_pkg::word_t            write_data
);

  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  logic                busy;  // read in flight
  logic [CNT_BITS-1:0] cnt;   // cycles left until read data shows

  // read goes out in the request cycle, one request at a time
  assign mem_rd_en   = refill_req && !busy;
  assign mem_rd_addr = refill_addr[2 +: $clog2(MEM_WORDS)];  // word index, wraps at MEM_WORDS

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      cnt        <= '0;
      fetch      <= 1'b0;
      write_data <= '0;
    end else begin
      fetch <= 1'b0;
      if (mem_rd_en) begin
        busy <= 1'b1;
        cnt  <= CNT_BITS'(MEM_LATENCY - 1);
      end else if (busy) begin
        if (cnt == '0) begin
          busy       <= 1'b0;
          fetch      <= 1'b1;         // MEM_LATENCY+1 after refill_req
          write_data <= mem_rd_data;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/sync_ram.sv
/* single-port synchronous RAM with registered read
   read-before-write, payload type chosen per instance */
`default_nettype none

module sync_ram #(
  parameter int  DEPTH     = 256,
  parameter type payload_t = icache_pkg::word_t
) (
  input  logic               CLK,
  input  logic               en,     // port enable, read or write
  input  logic               we,
  input  icache_pkg::index_t addr,
  input  payload_t           wdata,
  output payload_t           rdata
);

  payload_t mem [DEPTH];  // block RAM, no init

  always_ff @(posedge CLK) begin
    if (en) begin
      if (we) mem[addr] <= wdata;
      rdata <= mem[addr];  // old contents on a write
    end
  end

endmodule

`default_nettype wire

// File: sources.f
logic/icache_pkg.sv
logic/sync_ram.sv
logic/lru_ctrl.sv
logic/refill_ctrl.sv
logic/main_mem.sv
logic/icache.sv
logic/icache_top.sv
test/icache_tb.sv

// File: test/icache_tb.sv
/* testbench for the instruction cache subsystem
   boot-loads main memory, then checks scripted and random reads against an LRU model */
`default_nettype none

module icache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int MEM_LATENCY  = 3;
  localparam int MEM_WORDS    = 1024;
  localparam int MEM_AW       = $clog2(MEM_WORDS);
  localparam int SETS         = 2 ** INDEX_BITS;
  localparam int RESET_CYCLES = 8;
  localparam int SWEEP_CYCLES = SETS;           // one tag set written per cycle
  localparam int MISS_LIMIT   = MEM_LATENCY + 8;
  localparam int N_STREAM     = 16;
  localparam int N_EVICT      = 15;
  localparam int N_RANDOM     = 120;
  localparam int N_READS      = 6 + N_STREAM + N_EVICT + N_RANDOM;
  // worst read is a miss plus its reissue, doubled for margin
  localparam int CYCLE_LIMIT  = RESET_CYCLES + SWEEP_CYCLES + MEM_WORDS
                              + N_READS * 2 * (MEM_LATENCY + 8) + 100;

  logic              CLK;
  logic              rst_n;
  logic              read_en;
  addr_t             read_addr;
  word_t             rdata;
  logic              cache_miss;
  logic              load_en;
  logic [MEM_AW-1:0] load_addr;
  word_t             load_data;

  int checks = 0;
  int errors = 0;
  int since_rst;  // cycles since reset release, saturates

  // reference model, one entry per set and way
  word_t               mem_copy [MEM_WORDS];
  logic                m_valid  [SETS][WAYS];
  logic [TAG_BITS-1:0] m_tag    [SETS][WAYS];
  int                  m_age    [SETS][WAYS];
  addr_t               hit_list [$];

  // 4 = the lone line in the neighbour set
  int stream_order [N_STREAM] = '{0, 1, 2, 3, 4, 3, 3, 0, 2, 4, 1, 1, 0, 3, 4, 2};
  int evict_order  [N_EVICT]  = '{0, 1, 2, 3, 0, 4, 1, 0, 2, 3, 4, 1, 0, 4, 4};
  logic [TAG_BITS-1:0] evict_tags [5] = '{10'h000, 10'h0a5, 10'h15a, 10'h2f0, 10'h3ff};
  logic [TAG_BITS-1:0] rand_tags  [6] = '{10'h000, 10'h001, 10'h155, 10'h2aa, 10'h3ff,
                                         10'h0f0};
  index_t              rand_idx   [3] = '{8'h01, 8'h80, 8'hff};

  icache_top #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) dut0 (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .read_en    (read_en),
    .read_addr  (read_addr),
    .rdata      (rdata),
    .cache_miss (cache_miss),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;  // 40 ns period
  end

  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) since_rst <= 0;
    else if (since_rst <= SWEEP_CYCLES) since_rst <= since_rst + 1;
  end

  // no read possible while tags are being cleared
  sweep_miss_high: assert property (
    @(posedge CLK) disable iff (!rst_n) (since_rst < SWEEP_CYCLES) |-> cache_miss)
    else begin
      errors++;
      $display("Fail cache_miss: expected %h, got %h during sweep", 1'b1,
               $sampled(cache_miss));
    end

  miss_known: assert property (@(posedge CLK) disable iff (!rst_n) !$isunknown(cache_miss))
    else flag_problem("cache_miss is unknown after reset");

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: expected %h, got %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic flag_problem(input string msg);
    errors++;
    $display("%s at %0t", msg, $time);
  endtask

  function automatic addr_t make_addr(input logic [TAG_BITS-1:0] tag, input index_t idx);
    return {tag, idx, 2'b00};
  endfunction

  function automatic word_t expected_word(input addr_t a);
    return mem_copy[(a >> 2) % MEM_WORDS];  // word address wraps at memory depth
  endfunction

  // one access in the LRU model, returns whether it hit
  task automatic model_access(input addr_t a, output logic was_hit);
    int idx;
    int sel;
    int old_age;
    logic [TAG_BITS-1:0] t;
    idx = int'(a[2 +: INDEX_BITS]);
    t   = a[ADDR_BITS-1 -: TAG_BITS];
    sel = -1;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (m_valid[idx][w] && m_tag[idx][w] == t) sel = w;
    end
    was_hit = (sel >= 0);
    if (!was_hit) begin
      for (int w = WAYS - 1; w >= 0; w--) begin
        if (!m_valid[idx][w]) sel = w;  // lowest free way
      end
      if (sel < 0) begin
        sel = 0;
        for (int w = 1; w < WAYS; w++) begin
          if (m_age[idx][w] > m_age[idx][sel]) sel = w;  // oldest, first on a tie
        end
      end
    end
    old_age = m_age[idx][sel];
    for (int w = 0; w < WAYS; w++) begin
      if (w != sel && m_age[idx][w] < old_age) m_age[idx][w]++;
    end
    m_age[idx][sel]   = 0;
    m_valid[idx][sel] = 1'b1;
    m_tag[idx][sel]   = t;
  endtask

  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      load_en     = 1'b1;
      load_addr   = MEM_AW'(i);
      load_data   = $urandom;
      mem_copy[i] = load_data;
      @(negedge CLK);
    end
    load_en = 1'b0;
  endtask

  // one-cycle read strobe, address held afterwards
  task automatic issue_read(input addr_t a);
    read_en   = 1'b1;
    read_addr = a;
    @(negedge CLK);
    read_en = 1'b0;
  endtask

  task automatic wait_miss_end(output int n);
    n = 0;
    while (cache_miss && n < MISS_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (cache_miss) flag_problem("cache_miss never fell after a miss");
    @(negedge CLK);  // fill cycle over, back in IDLE
  endtask

  task automatic read_and_check(input addr_t a);
    logic hit;
    logic again;
    int   n;
    model_access(a, hit);
    issue_read(a);
    compare_value("cache_miss", !hit, cache_miss);
    if (!cache_miss) begin
      compare_value("rdata", expected_word(a), rdata);
    end else begin
      wait_miss_end(n);
      compare_value("miss_cycles", MEM_LATENCY + 2, n);  // compare cycle plus refill
      model_access(a, again);
      issue_read(a);  // processor reissues
      compare_value("cache_miss", !again, cache_miss);
      if (cache_miss) wait_miss_end(n);
      else compare_value("rdata", expected_word(a), rdata);
    end
    @(negedge CLK);
  endtask

  // read_en held high, a new address every cycle that shows a result
  task automatic stream_hits();
    int   i;
    int   hold;
    logic hit;
    i         = 0;
    hold      = 0;
    read_en   = 1'b1;
    read_addr = hit_list[0];
    while (i < hit_list.size() && hold <= MISS_LIMIT) begin
      @(negedge CLK);
      if (cache_miss) begin
        hold++;  // one cycle while tags are reread after a write-back
        if (hold == 2) flag_problem("cache_miss stayed high inside a run of hits");
      end else begin
        model_access(hit_list[i], hit);
        if (!hit) flag_problem("stream address not resident in the model");
        compare_value("rdata", expected_word(hit_list[i]), rdata);
        i++;
        hold = 0;
        if (i < hit_list.size()) read_addr = hit_list[i];
        else read_en = 1'b0;
      end
    end
    read_en = 1'b0;
    @(negedge CLK);
  endtask

  initial begin
    int n;
    void'($urandom(32'h302c));  // one seed for the whole run
    rst_n     = 1'b0;
    read_en   = 1'b0;
    read_addr = '0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_age[s][w]   = w;  // sweep ages A..D = 0..3
      end
    end
    repeat (RESET_CYCLES) @(negedge CLK);
    rst_n = 1'b1;

    // sweep length seen from outside
    n = 0;
    while (cache_miss && n <= SWEEP_CYCLES + 4) begin
      n++;
      @(negedge CLK);
    end
    compare_value("sweep_cycles", SWEEP_CYCLES, n);
    load_memory();

    read_and_check(make_addr(10'h2c3, 8'h3c));  // cold line

    // fill one set completely plus a neighbour, then hit them back to back
    for (int t = 0; t < 4; t++) begin
      read_and_check(make_addr(10'h100 + t, 8'h10));
    end
    read_and_check(make_addr(10'h104, 8'h11));
    foreach (stream_order[k]) begin
      if (stream_order[k] == 4) hit_list.push_back(make_addr(10'h104, 8'h11));
      else hit_list.push_back(make_addr(10'h100 + stream_order[k], 8'h10));
    end
    stream_hits();

    // five tags fighting over one set
    foreach (evict_order[k]) begin
      read_and_check(make_addr(evict_tags[evict_order[k]], 8'h5a));
    end

    // random mix, 6 tags over 3 sets
    for (int k = 0; k < N_RANDOM; k++) begin
      read_and_check(make_addr(rand_tags[$urandom % 6], rand_idx[$urandom % 3]));
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // hang guard
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
